//--- verilog.f
common/iqLinkPkg.sv
common/symbolIf.sv
logic/syncFifo.sv
logic/qamMapper.sv
cordic/cordicVector.sv
logic/qamSlicer.sv
logic/iqLinkTop.sv
dv/iqLinkTb.sv

//--- dv/iqLinkTb.sv
`timescale 1ns/1ps

module iqLinkTb;
	import iqLinkPkg::*;

	localparam int CLOCK_PERIOD   = 40;
	localparam int RESET_CYCLES   = 8;
	localparam int ITEM_WAIT      = 20;                // Cycles allowed for one item
	localparam int TIMEOUT_CYCLES = 2000;              // 103 items, ~10 cycles each plus stalls

	logic               clock;
	logic               rstN;
	logic               writeEnable;
	nibbleT             writeData;
	logic               inFull;
	logic               readEnable;
	nibbleT             readData;
	logic [MAG_W-1:0]   readMagnitude;
	logic [PHASE_W-1:0] readPhase;
	logic               outEmpty;

	int          cycleCount = 0;
	int          checkCount = 0;
	int          errorCount = 0;
	int          testCount  = 0;
	logic [31:0] lcgState   = 32'haa05_d15c;
	linkResultT  expectQ [$];                          // Written, not yet read

	iqLinkTop dut_i (
		.clock         (clock),
		.rstN          (rstN),
		.writeEnable   (writeEnable),
		.writeData     (writeData),
		.inFull        (inFull),
		.readEnable    (readEnable),
		.readData      (readData),
		.readMagnitude (readMagnitude),
		.readPhase     (readPhase),
		.outEmpty      (outEmpty)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) cycleCount <= cycleCount + 1;

	initial begin
		wait (cycleCount >= TIMEOUT_CYCLES);
		$display("Timeout, run passed %0d cycles without finishing", TIMEOUT_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////
	function automatic int axisLevel(input logic [1:0] code);
		case (code)                                      // Gray order -3 -1 +1 +3
			2'b00: return -3 * LEVEL_SCALE;
			2'b01: return -1 * LEVEL_SCALE;
			2'b11: return LEVEL_SCALE;
			default: return 3 * LEVEL_SCALE;
		endcase
	endfunction

	function automatic int atanStep(input int k);
		case (k)                                         // atan(2^-k), 256 per turn
			0: return 32;
			1: return 19;
			2: return 10;
			3: return 5;
			default: return 3;
		endcase
	endfunction

	function automatic linkResultT modelResult(input nibbleT nibble);
		int         x;
		int         y;
		int         angle;
		int         xNext;
		linkResultT result;
		x     = axisLevel(nibble[3:2]);
		y     = axisLevel(nibble[1:0]);
		angle = 0;
		if (x < 0) begin                                 // Fold into right half-plane
			x     = -x;
			y     = -y;
			angle = 128;
		end
		for (int k = 0; k < CORDIC_ITER; k++) begin
			if (y >= 0) begin
				xNext = x + (y >>> k);
				y     = y - (x >>> k);
				angle = angle + atanStep(k);
			end else begin
				xNext = x - (y >>> k);
				y     = y + (x >>> k);
				angle = angle - atanStep(k);
			end
			x = xNext;
		end
		result.nibble    = nibble;
		result.magnitude = MAG_W'(x);
		result.phase     = PHASE_W'(angle);              // Wraps mod 256
		return result;
	endfunction

	// Phase within a quarter turn of the quadrant centre
	function automatic bit inExpectedQuadrant(input nibbleT nibble, input logic [7:0] phase);
		logic [7:0] center;
		logic [7:0] offset;
		if (axisLevel(nibble[3:2]) > 0) begin
			center = (axisLevel(nibble[1:0]) > 0) ? 8'd32 : 8'd224;
		end else begin
			center = (axisLevel(nibble[1:0]) > 0) ? 8'd96 : 8'd160;
		end
		offset = phase - center;
		return (offset < 8'd32) || (offset > 8'd224);
	endfunction

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkNibble(input string testName, input nibbleT expVal,
			input nibbleT actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errorCount++;
			$display("ERR %s nibble expected %h actual %h", testName, expVal, actVal);
		end
	endtask

	task automatic checkPolar(input string testName, input polarT expVal, input polarT actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errorCount++;
			$display("ERR %s polar expected mag %0d phase %0d actual mag %0d phase %0d",
				testName, expVal.magnitude, expVal.phase, actVal.magnitude, actVal.phase);
		end
	endtask

	task automatic checkFlag(input string testName, input string what, input bit expVal,
			input bit actVal);
		checkCount++;
		if (actVal !== expVal) begin
			errorCount++;
			$display("ERR %s %s expected %0b actual %0b", testName, what, expVal, actVal);
		end
	endtask

	// Head of the output FIFO against the model
	task automatic compareOutput(input string testName, input linkResultT expected);
		polarT expPolar;
		polarT actPolar;
		expPolar.magnitude = expected.magnitude;
		expPolar.phase     = expected.phase;
		actPolar.magnitude = readMagnitude;
		actPolar.phase     = readPhase;
		checkNibble(testName, expected.nibble, readData);
		checkPolar(testName, expPolar, actPolar);
	endtask

	//////////////////////////////////////////////////
	// Drivers, all called just after a falling edge
	//////////////////////////////////////////////////
	task automatic sendNibble(input nibbleT nibble);
		writeEnable = 1'b1;
		writeData   = nibble;
		expectQ.push_back(modelResult(nibble));
		@(negedge clock);
		writeEnable = 1'b0;
	endtask

	task automatic waitForOutput(input string testName, output bit arrived);
		int waited;
		waited = 0;
		while (outEmpty && waited < ITEM_WAIT) begin
			@(negedge clock);
			waited++;
		end
		arrived = !outEmpty;
		if (!arrived) begin
			errorCount++;
			$display("%s: output FIFO stayed empty for %0d cycles", testName, ITEM_WAIT);
			expectQ.delete();                              // Lost item, realign
		end
	endtask

	task automatic popAndCheck(input string testName);
		linkResultT expected;
		expected = expectQ.pop_front();
		compareOutput(testName, expected);
		readEnable = 1'b1;
		@(negedge clock);
		readEnable = 1'b0;
	endtask

	// Writes and reads in the same cycle loop
	task automatic streamItems(input string testName, input int total, input bit holdReads);
		int          written;
		int          readCount;
		int          idleCycles;
		int          cycle;
		bit          sawFull;
		bit          readsOpen;
		bit          stalled;
		logic [31:0] rand32;
		nibbleT      nibble;
		linkResultT  expected;
		written    = 0;
		readCount  = 0;
		idleCycles = 0;
		cycle      = 0;
		sawFull    = 1'b0;
		stalled    = 1'b0;
		while (readCount < total && !stalled) begin
			rand32  = lcgNext();
			sawFull = sawFull || inFull;
			// Every other cycle leaves gaps frozen in the CORDIC, so inFull rises
			if (written < total && !inFull && (!holdReads || cycle % 2 == 0)) begin
				nibble      = holdReads ? nibbleT'(written * 7 + 3) : rand32[31:28];
				writeEnable = 1'b1;
				writeData   = nibble;
				expectQ.push_back(modelResult(nibble));
				written++;
			end else begin
				writeEnable = 1'b0;
			end
			readsOpen = holdReads ? (sawFull || written == total) : rand32[27];
			if (readsOpen && !outEmpty) begin
				expected = expectQ.pop_front();
				compareOutput(testName, expected);
				readEnable = 1'b1;
				readCount++;
			end else begin
				readEnable = 1'b0;
			end
			idleCycles = (outEmpty && expectQ.size() > 0) ? idleCycles + 1 : 0;
			if (idleCycles > ITEM_WAIT) begin
				errorCount++;
				stalled = 1'b1;
				$display("%s: output FIFO stayed empty with %0d items outstanding",
					testName, expectQ.size());
			end
			@(negedge clock);
			cycle++;
		end
		writeEnable = 1'b0;
		readEnable  = 1'b0;
		expectQ.delete();
		if (holdReads) begin
			checkFlag(testName, "inFull raised", 1'b1, sawFull);
		end
	endtask

	task automatic reportTest(input string testName, input int startErrors);
		testCount++;
		if (errorCount == startErrors) begin
			$display("%s: ok", testName);
		end else begin
			$display("%s: %0d errors", testName, errorCount - startErrors);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////
	task automatic testReset();
		int startErrors;
		bit arrived;
		startErrors = errorCount;
		checkFlag("testReset", "outEmpty", 1'b1, outEmpty);
		checkFlag("testReset", "inFull", 1'b0, inFull);
		readEnable = 1'b1;                               // Pop on empty, must be ignored
		@(negedge clock);
		readEnable = 1'b0;
		checkFlag("testReset", "outEmpty after empty read", 1'b1, outEmpty);
		sendNibble(4'h9);
		waitForOutput("testReset", arrived);
		if (arrived) begin
			popAndCheck("testReset");
		end
		reportTest("testReset", startErrors);
	endtask

	task automatic testAllSymbols();
		int startErrors;
		bit arrived;
		startErrors = errorCount;
		for (int v = 0; v < 16; v++) begin
			sendNibble(nibbleT'(v));
			waitForOutput("testAllSymbols", arrived);
			if (arrived) begin
				checkFlag("testAllSymbols", "phase quadrant", 1'b1,
					inExpectedQuadrant(nibbleT'(v), readPhase));
				popAndCheck("testAllSymbols");
			end
		end
		reportTest("testAllSymbols", startErrors);
	endtask

	task automatic testBackPressure();
		int startErrors;
		startErrors = errorCount;
		streamItems("testBackPressure", 22, 1'b1);
		reportTest("testBackPressure", startErrors);
	endtask

	task automatic testRandomStream();
		int startErrors;
		startErrors = errorCount;
		streamItems("testRandomStream", 64, 1'b0);
		reportTest("testRandomStream", startErrors);
	endtask

	task automatic testEmptyAfterDrain();
		int startErrors;
		startErrors = errorCount;
		repeat (ITEM_WAIT) @(negedge clock);             // Nothing may still be in flight
		checkFlag("testEmptyAfterDrain", "outEmpty", 1'b1, outEmpty);
		checkFlag("testEmptyAfterDrain", "inFull", 1'b0, inFull);
		reportTest("testEmptyAfterDrain", startErrors);
	endtask

	initial begin
		rstN        = 1'b0;
		writeEnable = 1'b0;
		writeData   = '0;
		readEnable  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		testReset();
		testAllSymbols();
		testBackPressure();
		testRandomStream();
		testEmptyAfterDrain();
		$display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- logic/iqLinkTop.sv
`timescale 1ns/1ps

module iqLinkTop (
	input  logic                          clock,
	input  logic                          rstN,
	input  logic                          writeEnable,
	input  logic [iqLinkPkg::DATA_W-1:0]  writeData,
	output logic                          inFull,
	input  logic                          readEnable,
	output logic [iqLinkPkg::DATA_W-1:0]  readData,
	output logic [iqLinkPkg::MAG_W-1:0]   readMagnitude,
	output logic [iqLinkPkg::PHASE_W-1:0] readPhase,
	output logic                          outEmpty
);
	import iqLinkPkg::*;

	nibbleT       inHead;                            // Input FIFO head
	logic         inEmpty;
	logic         mapperPop;
	logic         cordicValid;
	logic         slicerReady;
	cordicResultT cordicResult;
	logic         slicerPush;
	linkResultT   slicerItem;
	logic         outFull;
	linkResultT   outHead;                           // Output FIFO head

	symbolIf symbolBus ();                           // Mapper to CORDIC

	//////////////////////////////////////////////////
	// Input FIFO and mapper
	//////////////////////////////////////////////////
	syncFifo #(.ItemT(nibbleT), .DEPTH(IN_DEPTH)) inFifo (
		.clock    (clock),
		.rstN     (rstN),
		.push     (writeEnable),
		.pushItem (writeData),
		.full     (inFull),
		.pop      (mapperPop),
		.headItem (inHead),
		.empty    (inEmpty)
	);

	qamMapper mapper (
		.clock     (clock),
		.rstN      (rstN),
		.fifoEmpty (inEmpty),
		.fifoHead  (inHead),
		.fifoPop   (mapperPop),
		.symOut    (symbolBus.source)
	);

	cordicVector cordic (
		.clock     (clock),
		.rstN      (rstN),
		.symIn     (symbolBus.sink),
		.outValid  (cordicValid),
		.outReady  (slicerReady),
		.outResult (cordicResult)
	);

	//////////////////////////////////////////////////
	// Slicer and output FIFO
	//////////////////////////////////////////////////
	qamSlicer slicer (
		.inValid  (cordicValid),
		.inReady  (slicerReady),
		.inResult (cordicResult),
		.fifoFull (outFull),
		.fifoPush (slicerPush),
		.fifoItem (slicerItem)
	);

	syncFifo #(.ItemT(linkResultT), .DEPTH(OUT_DEPTH)) outFifo (
		.clock    (clock),
		.rstN     (rstN),
		.push     (slicerPush),
		.pushItem (slicerItem),
		.full     (outFull),
		.pop      (readEnable),
		.headItem (outHead),
		.empty    (outEmpty)
	);

	assign readData      = outHead.nibble;           // Valid while outEmpty low
	assign readMagnitude = outHead.magnitude;
	assign readPhase     = outHead.phase;

endmodule

//--- logic/qamSlicer.sv
`timescale 1ns/1ps

module qamSlicer (
	input  logic                    inValid,
	output logic                    inReady,
	input  iqLinkPkg::cordicResultT inResult,
	input  logic                    fifoFull,
	output logic                    fifoPush,
	output iqLinkPkg::linkResultT   fifoItem
);
	import iqLinkPkg::*;

	// Sign gives the high bit, inner ring the low bit
	function automatic logic [1:0] sliceAxis(input sampleT sample);
		sampleT absVal;
		absVal = (sample < 0) ? -sample : sample;
		return {sample > 0, absVal < SLICE_THRESHOLD};
	endfunction

	nibbleT decided;                                 // Recovered nibble

	assign decided  = {sliceAxis(inResult.symbol.iVal), sliceAxis(inResult.symbol.qVal)};
	assign inReady  = !fifoFull;                     // Stall CORDIC on full FIFO
	assign fifoPush = inValid && !fifoFull;

	always_comb begin
		fifoItem.nibble    = decided;
		fifoItem.magnitude = inResult.polar.magnitude;
		fifoItem.phase     = inResult.polar.phase;
	end

	// Mapper and slicer tables must be inverses
	always_comb begin
		if (fifoPush) begin
			nibbleRoundTrip: assert final (decided == inResult.bits);
		end
	end

endmodule

//--- cordic/cordicVector.sv
`timescale 1ns/1ps

module cordicVector (
	input  logic                    clock,
	input  logic                    rstN,
	symbolIf.sink                   symIn,
	output logic                    outValid,
	input  logic                    outReady,
	output iqLinkPkg::cordicResultT outResult
);
	import iqLinkPkg::*;

	//////////////////////////////////////////////////
	// Pipeline registers, index 0 is pre-rotation
	//////////////////////////////////////////////////
	logic [CORDIC_LAT-1:0]    stageValid;
	logic signed [MAG_W-1:0]  xReg [CORDIC_LAT];
	logic signed [MAG_W-1:0]  yReg [CORDIC_LAT];
	logic [PHASE_W-1:0]       angleReg [CORDIC_LAT];
	iqSymbolT                 symbolReg [CORDIC_LAT];
	nibbleT                   bitsReg [CORDIC_LAT];

	logic signed [MAG_W-1:0]  xIn;                   // Sign-extended I
	logic signed [MAG_W-1:0]  yIn;                   // Sign-extended Q

	assign xIn         = MAG_W'(symIn.iVal);
	assign yIn         = MAG_W'(symIn.qVal);
	assign symIn.ready = outReady;                   // Whole pipe moves as one

	always_ff @(posedge clock) begin
		if (!rstN) begin
			stageValid <= '0;
		end else if (outReady) begin
			stageValid <= {stageValid[CORDIC_LAT-2:0], symIn.valid};
		end
	end

	always_ff @(posedge clock) begin
		if (outReady) begin
			// Fold left half-plane onto the right
			if (symIn.iVal < 0) begin
				xReg[0]     <= -xIn;
				yReg[0]     <= -yIn;
				angleReg[0] <= HALF_TURN;
			end else begin
				xReg[0]     <= xIn;
				yReg[0]     <= yIn;
				angleReg[0] <= '0;
			end
			symbolReg[0].iVal <= symIn.iVal;
			symbolReg[0].qVal <= symIn.qVal;
			bitsReg[0]        <= symIn.bits;

			// Drive y toward zero, accumulate the angle
			for (int k = 0; k < CORDIC_ITER; k++) begin
				if (yReg[k] >= 0) begin
					xReg[k+1]     <= xReg[k] + (yReg[k] >>> k);
					yReg[k+1]     <= yReg[k] - (xReg[k] >>> k);
					angleReg[k+1] <= angleReg[k] + ATAN_TABLE[k];  // Wraps mod 256
				end else begin
					xReg[k+1]     <= xReg[k] - (yReg[k] >>> k);
					yReg[k+1]     <= yReg[k] + (xReg[k] >>> k);
					angleReg[k+1] <= angleReg[k] - ATAN_TABLE[k];
				end
				symbolReg[k+1] <= symbolReg[k];      // Payload travels along
				bitsReg[k+1]   <= bitsReg[k];
			end
		end
	end

	//////////////////////////////////////////////////
	// Last stage out
	//////////////////////////////////////////////////
	assign outValid = stageValid[CORDIC_LAT-1];

	always_comb begin
		outResult.symbol          = symbolReg[CORDIC_LAT-1];
		outResult.bits            = bitsReg[CORDIC_LAT-1];
		outResult.polar.magnitude = unsigned'(xReg[CORDIC_LAT-1]);  // Gain ~1.65 kept
		outResult.polar.phase     = angleReg[CORDIC_LAT-1];
	end

	// Valid chain must be fully defined once out of reset
	validKnown: assert property (@(posedge clock) disable iff (!rstN)
		!$isunknown(stageValid));

endmodule

//--- logic/qamMapper.sv
`timescale 1ns/1ps

module qamMapper (
	input  logic              clock,
	input  logic              rstN,
	input  logic              fifoEmpty,
	input  iqLinkPkg::nibbleT fifoHead,
	output logic              fifoPop,
	symbolIf.source           symOut
);
	import iqLinkPkg::*;

	// Gray code per axis: 00 -3, 01 -1, 11 +1, 10 +3
	function automatic sampleT grayLevel(input logic [1:0] code);
		unique case (code)
			2'b00: return sampleT'(-3 * LEVEL_SCALE);
			2'b01: return sampleT'(-1 * LEVEL_SCALE);
			2'b11: return sampleT'(LEVEL_SCALE);
			2'b10: return sampleT'(3 * LEVEL_SCALE);
		endcase
	endfunction

	// Pop when output register is free or being taken
	assign fifoPop = !fifoEmpty && (!symOut.valid || symOut.ready);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			symOut.valid <= 1'b0;
		end else if (fifoPop) begin
			symOut.valid <= 1'b1;                    // New symbol loaded
		end else if (symOut.ready) begin
			symOut.valid <= 1'b0;                    // Taken, nothing behind it
		end
	end

	always_ff @(posedge clock) begin
		if (fifoPop) begin
			symOut.iVal <= grayLevel(fifoHead[3:2]);  // I from high bits
			symOut.qVal <= grayLevel(fifoHead[1:0]);  // Q from low bits
			symOut.bits <= fifoHead;
		end
	end

	// Held symbol waits for the CORDIC without changing
	holdUntilTaken: assert property (@(posedge clock) disable iff (!rstN)
		symOut.valid && !symOut.ready |=> symOut.valid && $stable(symOut.bits));

endmodule

//--- logic/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
	parameter type ItemT = logic [3:0],
	parameter int  DEPTH = 8
) (
	input  logic clock,
	input  logic rstN,
	input  logic push,
	input  ItemT pushItem,
	output logic full,
	input  logic pop,
	output ItemT headItem,
	output logic empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	ItemT             mem [DEPTH];                   // Storage, no reset
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;                         // Items held
	logic             doPush;
	logic             doPop;

	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);
	assign doPush   = push && !full;                 // Drop push when full
	assign doPop    = pop && !empty;                 // Drop pop when empty
	assign headItem = mem[rdPtr];                    // First word falls through

	always_ff @(posedge clock) begin
		if (doPush) begin
			mem[wrPtr] <= pushItem;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;  // Wrap
			end
			if (doPop) begin
				rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			end
			count <= count + CNT_W'(doPush) - CNT_W'(doPop);  // Both may happen
		end
	end

	// Occupancy stays in range over any push/pop sequence
	countInRange: assert property (@(posedge clock) disable iff (!rstN)
		count <= CNT_W'(DEPTH));

	flagsExclusive: assert property (@(posedge clock) disable iff (!rstN)
		!(empty && full));

endmodule

//--- common/symbolIf.sv
`timescale 1ns/1ps

interface symbolIf;
	import iqLinkPkg::*;

	logic   valid;                                   // Symbol present
	logic   ready;                                   // Sink can take it
	sampleT iVal;
	sampleT qVal;
	nibbleT bits;                                    // Nibble behind the symbol

	modport source (
		output valid,
		output iVal,
		output qVal,
		output bits,
		input  ready
	);

	modport sink (
		input  valid,
		input  iVal,
		input  qVal,
		input  bits,
		output ready
	);

endinterface

//--- common/iqLinkPkg.sv
package iqLinkPkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////
	localparam int DATA_W      = 4;                  // One 16-QAM nibble
	localparam int SAMPLE_W    = 8;                  // Signed I/Q sample
	localparam int MAG_W       = 10;                 // Magnitude incl. CORDIC gain
	localparam int PHASE_W     = 8;                  // Binary angle, 256 per turn
	localparam int CORDIC_ITER = 5;                  // Micro-rotations
	localparam int CORDIC_LAT  = CORDIC_ITER + 1;    // Pre-rotation plus iterations
	localparam int IN_DEPTH    = 8;
	localparam int OUT_DEPTH   = 8;

	//////////////////////////////////////////////////
	// Constellation and angle constants
	//////////////////////////////////////////////////
	localparam int LEVEL_SCALE     = 4;              // +-1, +-3 become +-4, +-12
	localparam int SLICE_THRESHOLD = 8;              // Inner/outer ring boundary

	localparam logic [PHASE_W-1:0] HALF_TURN = 8'd128;  // 180 degrees

	// atan(2^-k) in binary-angle units, entry 0 is 45 degrees
	localparam logic [CORDIC_ITER-1:0][PHASE_W-1:0] ATAN_TABLE = {
		8'd3,
		8'd5,
		8'd10,
		8'd19,
		8'd32
	};

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////
	typedef logic [DATA_W-1:0] nibbleT;
	typedef logic signed [SAMPLE_W-1:0] sampleT;

	typedef struct packed {
		sampleT iVal;                                // In-phase
		sampleT qVal;                                // Quadrature
	} iqSymbolT;

	typedef struct packed {
		logic [MAG_W-1:0]   magnitude;
		logic [PHASE_W-1:0] phase;
	} polarT;

	// CORDIC output, the source symbol rides along
	typedef struct packed {
		iqSymbolT symbol;
		nibbleT   bits;                              // Nibble as sent by the mapper
		polarT    polar;
	} cordicResultT;

	// Output FIFO entry
	typedef struct packed {
		nibbleT             nibble;
		logic [MAG_W-1:0]   magnitude;
		logic [PHASE_W-1:0] phase;
	} linkResultT;

endpackage
